/* periph_pkg.sv */
// Shared definitions for the low-speed APB peripheral subsystem.
// Holds bus widths, the slot map, register offsets and the UART TX state encoding.
// Every RTL file and the testbench import from here.

package periph_pkg;

// ============================================================
//  Bus widths
// ============================================================

localparam int W_PADDR = 16;
localparam int W_DATA  = 32;

// Peripheral slot, taken from paddr[15:12]
typedef enum logic [3:0] {
	slot_gpio = 4'h0,
	slot_uart = 4'h1,
	slot_pwm  = 4'h2
} periph_slot_t;

// ============================================================
//  Register offsets within a slot
// ============================================================

localparam logic [W_PADDR-1:0] GPIO_OUT_OFFS    = 16'h0000;
localparam logic [W_PADDR-1:0] GPIO_OE_OFFS     = 16'h0004;
localparam logic [W_PADDR-1:0] GPIO_IN_OFFS     = 16'h0008; // Read only

localparam logic [W_PADDR-1:0] UART_TXDATA_OFFS = 16'h0000; // Write pushes low byte
localparam logic [W_PADDR-1:0] UART_CSR_OFFS    = 16'h0004;
localparam logic [W_PADDR-1:0] UART_DIV_OFFS    = 16'h0008;

localparam logic [W_PADDR-1:0] PWM_CSR_OFFS     = 16'h0000;
localparam logic [W_PADDR-1:0] PWM_DIV_OFFS     = 16'h0004;
localparam logic [W_PADDR-1:0] PWM_LEVEL_OFFS   = 16'h0008;

// UART transmitter FSM
typedef enum logic [1:0] {
	st_idle,
	st_start,
	st_data,
	st_stop
} uart_state_t;

endpackage

/* apb_splitter.sv */
// APB address splitter for the peripheral subsystem.
// Decodes paddr[15:12] into a slot, steers psel to one peripheral
// and muxes its response back. Unmapped slots get an error response.

`timescale 1ns/100ps

module apb_splitter (
	// From the APB master
	input  logic                            psel,
	input  logic                            penable,
	input  logic [periph_pkg::W_PADDR-1:0]  paddr,
	output logic [periph_pkg::W_DATA-1:0]   prdata,
	output logic                            pready,
	output logic                            pslverr,

	// Peripheral selects
	output logic                            gpio_psel,
	output logic                            uart_psel,
	output logic                            pwm_psel,

	// Peripheral responses
	input  logic [periph_pkg::W_DATA-1:0]   gpio_prdata,
	input  logic [periph_pkg::W_DATA-1:0]   uart_prdata,
	input  logic [periph_pkg::W_DATA-1:0]   pwm_prdata,
	input  logic                            uart_pready
);

import periph_pkg::*;

periph_slot_t slot;
logic         slot_hit;

assign slot = periph_slot_t'(paddr[15:12]);

always_comb begin
	gpio_psel = 1'b0;
	uart_psel = 1'b0;
	pwm_psel  = 1'b0;
	prdata    = '0;
	pready    = 1'b1; // GPIO and PWM never stall
	slot_hit  = 1'b1;
	case (slot)
		slot_gpio: begin
			gpio_psel = psel;
			prdata    = gpio_prdata;
		end
		slot_uart: begin
			uart_psel = psel;
			prdata    = uart_prdata;
			pready    = uart_pready; // Back-pressure on a full TX FIFO
		end
		slot_pwm: begin
			pwm_psel  = psel;
			prdata    = pwm_prdata;
		end
		default: begin
			slot_hit  = 1'b0;
		end
	endcase
end

// Error only on the access cycle of an unmapped transfer
assign pslverr = psel && penable && !slot_hit;

endmodule

/* gpio.sv */
// GPIO block on APB.
// OUT and OE registers drive the pads directly; IN reads padin
// through a two-flop synchronizer. Registers read back zero-extended.

`timescale 1ns/100ps

module gpio #(
	parameter int N_PADS = 11
) (
	input  logic                            clk,
	input  logic                            reset,

	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [periph_pkg::W_PADDR-1:0]  paddr,
	input  logic [periph_pkg::W_DATA-1:0]   pwdata,
	output logic [periph_pkg::W_DATA-1:0]   prdata,

	output logic [N_PADS-1:0]               padout,
	output logic [N_PADS-1:0]               padoe,
	input  logic [N_PADS-1:0]               padin
);

import periph_pkg::*;

logic [W_PADDR-1:0] reg_offs;
logic               bus_wr;
logic [N_PADS-1:0]  in_meta;
logic [N_PADS-1:0]  in_sync;

assign reg_offs = {4'h0, paddr[11:0]}; // Strip the slot bits
assign bus_wr   = psel && penable && pwrite;

always_ff @(posedge clk) begin
	if (reset) begin
		padout <= '0;
		padoe  <= '0;
	end else if (bus_wr) begin
		if (reg_offs == GPIO_OUT_OFFS)
			padout <= pwdata[N_PADS-1:0];
		if (reg_offs == GPIO_OE_OFFS)
			padoe  <= pwdata[N_PADS-1:0];
	end
end

// Pads are asynchronous to clk
always_ff @(posedge clk) begin
	in_meta <= padin;
	in_sync <= in_meta;
end

always_comb begin
	case (reg_offs)
		GPIO_OUT_OFFS: prdata = W_DATA'(padout);
		GPIO_OE_OFFS:  prdata = W_DATA'(padoe);
		GPIO_IN_OFFS:  prdata = W_DATA'(in_sync);
		default:       prdata = '0;
	endcase
end

endmodule

/* uart_tx_mini.sv */
// Transmit-only UART on APB.
// TXDATA pushes bytes into a small FIFO; the FSM sends 8N1 frames with
// DIV+1 cycles per bit. A write to a full FIFO stalls the bus via pready.

`timescale 1ns/100ps

module uart_tx_mini #(
	parameter int UART_FIFO_DEPTH = 4
) (
	input  logic                            clk,
	input  logic                            reset,

	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [periph_pkg::W_PADDR-1:0]  paddr,
	input  logic [periph_pkg::W_DATA-1:0]   pwdata,
	output logic [periph_pkg::W_DATA-1:0]   prdata,
	output logic                            pready,

	output logic                            uart_tx,
	output logic                            irq
);

import periph_pkg::*;

localparam int W_PTR = $clog2(UART_FIFO_DEPTH);

logic [W_PADDR-1:0] reg_offs;
logic               bus_wr;
logic               txdata_wr;

logic [7:0]         fifo_mem [UART_FIFO_DEPTH];
logic [W_PTR:0]     wptr; // Extra bit tells full from empty
logic [W_PTR:0]     rptr;
logic               fifo_empty;
logic               fifo_full;
logic               fifo_push;
logic               fifo_pop;

logic [7:0]         div;
logic               irq_en;
logic               busy;

uart_state_t        state;
logic [7:0]         bit_timer;
logic               bit_end;
logic [2:0]         bit_cnt;
logic [7:0]         shifter;

assign reg_offs  = {4'h0, paddr[11:0]};
assign bus_wr    = psel && penable && pwrite;
assign txdata_wr = bus_wr && (reg_offs == UART_TXDATA_OFFS);

assign fifo_empty = wptr == rptr;
assign fifo_full  = (wptr[W_PTR] != rptr[W_PTR]) &&
	(wptr[W_PTR-1:0] == rptr[W_PTR-1:0]);
assign fifo_push  = txdata_wr && !fifo_full;
assign pready     = !(txdata_wr && fifo_full);

assign bit_end  = bit_timer == 8'h00;
// Pop from idle, or straight after a stop bit for back-to-back frames
assign fifo_pop = !fifo_empty && (state == st_idle || (state == st_stop && bit_end));

assign busy = (state != st_idle) || !fifo_empty;
assign irq  = irq_en && fifo_empty && (state == st_idle);

// ============================================================
//  Register block and FIFO
// ============================================================

always_ff @(posedge clk) begin
	if (reset) begin
		div    <= 8'd15;
		irq_en <= 1'b0;
	end else if (bus_wr) begin
		if (reg_offs == UART_CSR_OFFS)
			irq_en <= pwdata[8];
		if (reg_offs == UART_DIV_OFFS)
			div    <= pwdata[7:0];
	end
end

always_ff @(posedge clk) begin
	if (fifo_push)
		fifo_mem[wptr[W_PTR-1:0]] <= pwdata[7:0];
end

always_ff @(posedge clk) begin
	if (reset) begin
		wptr <= '0;
		rptr <= '0;
	end else begin
		if (fifo_push)
			wptr <= wptr + 1'b1;
		if (fifo_pop)
			rptr <= rptr + 1'b1;
	end
end

always_comb begin
	case (reg_offs)
		UART_CSR_OFFS: prdata = W_DATA'({irq_en, 6'h00, fifo_full, busy});
		UART_DIV_OFFS: prdata = W_DATA'(div);
		default:       prdata = '0; // TXDATA is write only
	endcase
end

// ============================================================
//  Transmit FSM
// ============================================================

always_ff @(posedge clk) begin
	if (fifo_pop)
		shifter <= fifo_mem[rptr[W_PTR-1:0]];
	else if (state == st_data && bit_end)
		shifter <= shifter >> 1; // LSB first
end

always_ff @(posedge clk) begin
	if (reset) begin
		state     <= st_idle;
		bit_timer <= 8'h00;
		bit_cnt   <= 3'h0;
		uart_tx   <= 1'b1;
	end else begin
		if (state != st_idle && !bit_end)
			bit_timer <= bit_timer - 1'b1;
		case (state)
			st_idle: begin
				if (fifo_pop) begin
					state     <= st_start;
					bit_timer <= div;
					uart_tx   <= 1'b0;
				end
			end
			st_start: begin
				if (bit_end) begin
					state     <= st_data;
					bit_timer <= div;
					bit_cnt   <= 3'h0;
					uart_tx   <= shifter[0];
				end
			end
			st_data: begin
				if (bit_end) begin
					bit_timer <= div;
					bit_cnt   <= bit_cnt + 1'b1;
					if (bit_cnt == 3'h7) begin
						state   <= st_stop;
						uart_tx <= 1'b1;
					end else begin
						uart_tx <= shifter[1]; // Next bit after the shift
					end
				end
			end
			default: begin // Stop bit
				if (bit_end) begin
					if (fifo_pop) begin
						state     <= st_start;
						bit_timer <= div;
						uart_tx   <= 1'b0;
					end else begin
						state     <= st_idle;
					end
				end
			end
		endcase
	end
end

endmodule

/* pwm_tiny.sv */
// Backlight PWM on APB.
// A prescaler strobes an 8-bit counter; output is high while the
// counter is below LEVEL, optionally inverted, and registered.

`timescale 1ns/100ps

module pwm_tiny (
	input  logic                            clk,
	input  logic                            reset,

	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [periph_pkg::W_PADDR-1:0]  paddr,
	input  logic [periph_pkg::W_DATA-1:0]   pwdata,
	output logic [periph_pkg::W_DATA-1:0]   prdata,

	output logic                            lcd_pwm
);

import periph_pkg::*;

logic [W_PADDR-1:0] reg_offs;
logic               bus_wr;
logic               pwm_en;
logic               pwm_inv;
logic [7:0]         div;
logic [7:0]         level;
logic [7:0]         presc;
logic [7:0]         ctr;
logic               ctr_strobe;

assign reg_offs   = {4'h0, paddr[11:0]};
assign bus_wr     = psel && penable && pwrite;
assign ctr_strobe = presc >= div; // Also recovers if DIV shrinks mid-count

always_ff @(posedge clk) begin
	if (reset) begin
		pwm_en  <= 1'b0;
		pwm_inv <= 1'b0;
		div     <= 8'h00;
		level   <= 8'h00;
	end else if (bus_wr) begin
		case (reg_offs)
			PWM_CSR_OFFS: begin
				pwm_en  <= pwdata[0];
				pwm_inv <= pwdata[1];
			end
			PWM_DIV_OFFS:   div   <= pwdata[7:0];
			PWM_LEVEL_OFFS: level <= pwdata[7:0];
			default: ;
		endcase
	end
end

// Period is 256 * (DIV + 1) cycles
always_ff @(posedge clk) begin
	if (reset) begin
		presc <= 8'h00;
		ctr   <= 8'h00;
	end else if (!pwm_en) begin
		presc <= 8'h00;
		ctr   <= 8'h00;
	end else if (ctr_strobe) begin
		presc <= 8'h00;
		ctr   <= ctr + 1'b1; // Wraps after 255
	end else begin
		presc <= presc + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (reset)
		lcd_pwm <= 1'b0;
	else
		lcd_pwm <= pwm_en ? ((ctr < level) ^ pwm_inv) : pwm_inv;
end

always_comb begin
	case (reg_offs)
		PWM_CSR_OFFS:   prdata = W_DATA'({pwm_inv, pwm_en});
		PWM_DIV_OFFS:   prdata = W_DATA'(div);
		PWM_LEVEL_OFFS: prdata = W_DATA'(level);
		default:        prdata = '0;
	endcase
end

endmodule

/* periph_top.sv */
// Top level of the APB peripheral subsystem.
// Presents one APB slave port and wires the splitter to GPIO, UART TX and PWM.
// Pad, UART and backlight pins leave from here.

`timescale 1ns/100ps

module periph_top #(
	parameter int N_PADS          = 11,
	parameter int UART_FIFO_DEPTH = 4
) (
	input  logic                            clk_sys,
	input  logic                            reset,

	// APB slave port
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [periph_pkg::W_PADDR-1:0]  paddr,
	input  logic [periph_pkg::W_DATA-1:0]   pwdata,
	output logic [periph_pkg::W_DATA-1:0]   prdata,
	output logic                            pready,
	output logic                            pslverr,

	// Pins
	output logic [N_PADS-1:0]               padout,
	output logic [N_PADS-1:0]               padoe,
	input  logic [N_PADS-1:0]               padin,
	output logic                            uart_tx,
	output logic                            irq, // UART is the only source
	output logic                            lcd_pwm
);

import periph_pkg::*;

// ============================================================
//  Splitter to peripheral wiring
// ============================================================

logic              gpio_psel;
logic              uart_psel;
logic              pwm_psel;
logic [W_DATA-1:0] gpio_prdata;
logic [W_DATA-1:0] uart_prdata;
logic [W_DATA-1:0] pwm_prdata;
logic              uart_pready;

apb_splitter inst_apb_splitter (
	.psel        (psel),
	.penable     (penable),
	.paddr       (paddr),
	.prdata      (prdata),
	.pready      (pready),
	.pslverr     (pslverr),
	.gpio_psel   (gpio_psel),
	.uart_psel   (uart_psel),
	.pwm_psel    (pwm_psel),
	.gpio_prdata (gpio_prdata),
	.uart_prdata (uart_prdata),
	.pwm_prdata  (pwm_prdata),
	.uart_pready (uart_pready)
);

gpio #(
	.N_PADS (N_PADS)
) inst_gpio (
	.clk     (clk_sys),
	.reset   (reset),
	.psel    (gpio_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (gpio_prdata),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin)
);

uart_tx_mini #(
	.UART_FIFO_DEPTH (UART_FIFO_DEPTH)
) inst_uart_tx_mini (
	.clk     (clk_sys),
	.reset   (reset),
	.psel    (uart_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (uart_prdata),
	.pready  (uart_pready),
	.uart_tx (uart_tx),
	.irq     (irq)
);

pwm_tiny inst_pwm_tiny (
	.clk     (clk_sys),
	.reset   (reset),
	.psel    (pwm_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (pwm_prdata),
	.lcd_pwm (lcd_pwm)
);

endmodule

/* tb_periph_top.sv */
// Testbench for the APB peripheral subsystem.
// Acts as APB master and runs directed tests on GPIO, decode errors,
// UART data and interrupt, and the PWM. Prints a summary at the end.

`timescale 1ns/100ps

module tb_periph_top;

import periph_pkg::*;

localparam int N_PADS       = 11;
localparam int FIFO_DEPTH   = 4;
localparam int CLK_PERIOD   = 10;
localparam int UART_DIV     = 3;
localparam int N_UART_BYTES = 6;
localparam int EST_CYCLES   = 8000; // Generous estimate for all tests
localparam int MAX_CYCLES   = EST_CYCLES * 5 / 2;

logic              clk;
logic              reset;
logic              psel;
logic              penable;
logic              pwrite;
logic [W_PADDR-1:0] paddr;
logic [W_DATA-1:0] pwdata;
logic [W_DATA-1:0] prdata;
logic              pready;
logic              pslverr;
logic [N_PADS-1:0] padout;
logic [N_PADS-1:0] padoe;
logic [N_PADS-1:0] padin;
logic              uart_tx;
logic              irq;
logic              lcd_pwm;

logic [31:0] lfsr;
int          cycles = 0;
int          n_tests;
int          n_checks;
int          n_errors;
int          stall_cycles; // Access cycles with pready low

periph_top #(
	.N_PADS          (N_PADS),
	.UART_FIFO_DEPTH (FIFO_DEPTH)
) u_dut (
	.clk_sys (clk),
	.reset   (reset),
	.psel    (psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (prdata),
	.pready  (pready),
	.pslverr (pslverr),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin),
	.uart_tx (uart_tx),
	.irq     (irq),
	.lcd_pwm (lcd_pwm)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= MAX_CYCLES) begin
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST FAILED");
		$finish;
	end
end

// ============================================================
//  Helpers
// ============================================================

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		r    = {r[30:0], fb};
	end
	return r;
endfunction

function automatic logic [W_PADDR-1:0] reg_addr(input logic [3:0] slot,
	input logic [W_PADDR-1:0] offs);
	return {slot, offs[11:0]};
endfunction

task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
	n_checks++;
	if (actual !== expected) begin
		n_errors++;
		$display("CHECK FAILED at %0d ns: %s (got 0x%0h, expected 0x%0h)",
			$time, msg, actual, expected);
	end
endtask

task automatic report_test(input string name, input int errors_before);
	n_tests++;
	$display("%s done, %0d errors", name, n_errors - errors_before);
endtask

// Both APB tasks start and end 1 ns after a rising edge
task automatic apb_write(input logic [W_PADDR-1:0] addr, input logic [W_DATA-1:0] data,
	output logic err);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b1;
	paddr   = addr;
	pwdata  = data;
	@(posedge clk);
	#1;
	penable = 1'b1;
	@(negedge clk);
	while (!pready) begin
		stall_cycles++;
		@(negedge clk);
	end
	err = pslverr;
	@(posedge clk);
	#1;
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic apb_read(input logic [W_PADDR-1:0] addr, output logic [W_DATA-1:0] data,
	output logic err);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b0;
	paddr   = addr;
	@(posedge clk);
	#1;
	penable = 1'b1;
	@(negedge clk);
	while (!pready)
		@(negedge clk);
	data = prdata;
	err  = pslverr;
	@(posedge clk);
	#1;
	psel    = 1'b0;
	penable = 1'b0;
endtask

// Samples each bit in its middle, on a falling clock edge
task automatic receive_byte(output logic [7:0] data);
	logic [7:0] shift;
	@(negedge uart_tx);
	#(((UART_DIV + 1) / 2) * CLK_PERIOD + CLK_PERIOD / 2);
	check(32'(uart_tx), 0, "start bit");
	for (int b = 0; b < 8; b++) begin
		#((UART_DIV + 1) * CLK_PERIOD);
		shift = {uart_tx, shift[7:1]}; // LSB arrives first
	end
	#((UART_DIV + 1) * CLK_PERIOD);
	check(32'(uart_tx), 1, "stop bit");
	data = shift;
endtask

task automatic count_pwm_high(output int n);
	n = 0;
	repeat (256) begin
		@(negedge clk);
		if (lcd_pwm)
			n++;
	end
	@(posedge clk);
	#1;
endtask

// ============================================================
//  Tests
// ============================================================

task automatic gpio_regs_and_pins();
	int                base;
	logic [W_DATA-1:0] out_val;
	logic [W_DATA-1:0] oe_val;
	logic [W_DATA-1:0] pad_val;
	logic [W_DATA-1:0] rd;
	logic              err;
	base = n_errors;
	check(32'(padout), 0, "padout after reset");
	check(32'(padoe), 0, "padoe after reset");
	out_val = rand_bits(32);
	oe_val  = rand_bits(32);
	apb_write(reg_addr(slot_gpio, GPIO_OUT_OFFS), out_val, err);
	apb_write(reg_addr(slot_gpio, GPIO_OE_OFFS), oe_val, err);
	check(32'(padout), 32'(out_val[N_PADS-1:0]), "padout pins");
	check(32'(padoe), 32'(oe_val[N_PADS-1:0]), "padoe pins");
	apb_read(reg_addr(slot_gpio, GPIO_OUT_OFFS), rd, err);
	check(rd, 32'(out_val[N_PADS-1:0]), "OUT readback");
	apb_read(reg_addr(slot_gpio, GPIO_OE_OFFS), rd, err);
	check(rd, 32'(oe_val[N_PADS-1:0]), "OE readback");
	pad_val = rand_bits(N_PADS);
	padin   = pad_val[N_PADS-1:0];
	repeat (3) @(posedge clk);
	#1;
	apb_read(reg_addr(slot_gpio, GPIO_IN_OFFS), rd, err);
	check(rd, 32'(pad_val[N_PADS-1:0]), "IN after synchronizer");
	report_test("gpio", base);
endtask

task automatic decode_errors();
	int                base;
	logic [W_DATA-1:0] rd;
	logic              err;
	base = n_errors;
	apb_read(reg_addr(4'h3, 16'h0000), rd, err);
	check(32'(err), 1, "slot 3 read pslverr");
	check(rd, 0, "slot 3 read data");
	apb_write(reg_addr(4'hf, 16'h0004), 32'hdead_beef, err);
	check(32'(err), 1, "slot 15 write pslverr");
	apb_read(reg_addr(4'hf, 16'h0008), rd, err);
	check(32'(err), 1, "slot 15 read pslverr");
	check(rd, 0, "slot 15 read data");
	apb_read(reg_addr(slot_gpio, GPIO_IN_OFFS), rd, err);
	check(32'(err), 0, "GPIO slot pslverr");
	apb_read(reg_addr(slot_uart, UART_DIV_OFFS), rd, err);
	check(32'(err), 0, "UART slot pslverr");
	check(rd, 15, "UART DIV reset value");
	apb_read(reg_addr(slot_pwm, PWM_CSR_OFFS), rd, err);
	check(32'(err), 0, "PWM slot pslverr");
	check(rd, 0, "PWM CSR reset value");
	report_test("decode", base);
endtask

task automatic uart_byte_stream();
	int          base;
	logic [31:0] rnd;
	logic [7:0]  bytes [N_UART_BYTES];
	logic [7:0]  rx;
	logic        err;
	base = n_errors;
	for (int i = 0; i < N_UART_BYTES; i++) begin
		rnd      = rand_bits(8);
		bytes[i] = rnd[7:0];
	end
	apb_write(reg_addr(slot_uart, UART_DIV_OFFS), UART_DIV, err);
	stall_cycles = 0;
	fork
		for (int i = 0; i < N_UART_BYTES; i++)
			apb_write(reg_addr(slot_uart, UART_TXDATA_OFFS), 32'(bytes[i]), err);
		for (int j = 0; j < N_UART_BYTES; j++) begin
			receive_byte(rx);
			check(32'(rx), 32'(bytes[j]), "received byte");
		end
	join
	// More bytes than FIFO entries plus the shifter
	check(32'(stall_cycles > 0), 1, "TXDATA writes saw back-pressure");
	@(posedge clk);
	#1;
	report_test("uart data", base);
endtask

task automatic uart_interrupt();
	int                base;
	int                polls;
	int                waited;
	logic              busy;
	logic              risen;
	logic [W_DATA-1:0] rd;
	logic              err;
	base = n_errors;
	busy  = 1'b1;
	polls = 0;
	while (busy && polls < 100) begin
		apb_read(reg_addr(slot_uart, UART_CSR_OFFS), rd, err);
		busy = rd[0];
		polls++;
	end
	if (busy) begin
		n_errors++;
		$display("UART still busy after %0d status reads", polls);
	end
	// Idle with an empty FIFO, so only the enable keeps irq low
	check(32'(irq), 0, "irq with enable clear");
	apb_write(reg_addr(slot_uart, UART_CSR_OFFS), 32'h0000_0100, err);
	check(32'(irq), 1, "irq when enabled and idle");
	rd = rand_bits(8);
	apb_write(reg_addr(slot_uart, UART_TXDATA_OFFS), rd, err);
	check(32'(irq), 0, "irq low while busy");
	apb_read(reg_addr(slot_uart, UART_CSR_OFFS), rd, err);
	check(32'(rd[0]), 1, "CSR busy during frame");
	risen  = 1'b0;
	waited = 0;
	while (!risen && waited < 10 * (UART_DIV + 1) + 10) begin
		@(negedge clk);
		risen = irq;
		waited++;
	end
	n_checks++;
	if (!risen) begin
		n_errors++;
		$display("irq did not rise within %0d cycles of the frame", waited);
	end
	// Ten bits of DIV+1 cycles each, start bit at least one cycle after the push
	check(32'(waited >= 10 * (UART_DIV + 1)), 1, "irq not before the stop bit ends");
	@(posedge clk);
	#1;
	apb_read(reg_addr(slot_uart, UART_CSR_OFFS), rd, err);
	check(32'(rd[0]), 0, "CSR busy after frame");
	check(32'(rd[8]), 1, "CSR interrupt enable readback");
	apb_write(reg_addr(slot_uart, UART_CSR_OFFS), 0, err);
	check(32'(irq), 0, "irq after disable");
	report_test("uart irq", base);
endtask

task automatic pwm_duty_cycle();
	int          base;
	int          n;
	logic [31:0] rnd;
	logic [7:0]  level;
	logic        err;
	base  = n_errors;
	rnd   = rand_bits(8);
	level = rnd[7:0];
	apb_write(reg_addr(slot_pwm, PWM_DIV_OFFS), 0, err);
	apb_write(reg_addr(slot_pwm, PWM_LEVEL_OFFS), 32'(level), err);
	apb_write(reg_addr(slot_pwm, PWM_CSR_OFFS), 32'h1, err);
	repeat (4) @(posedge clk);
	#1;
	count_pwm_high(n);
	check(n, 32'(level), "high cycles per period");
	apb_write(reg_addr(slot_pwm, PWM_CSR_OFFS), 32'h3, err); // Enable and invert
	repeat (4) @(posedge clk);
	#1;
	count_pwm_high(n);
	check(n, 32'(256 - int'(level)), "high cycles inverted");
	apb_write(reg_addr(slot_pwm, PWM_CSR_OFFS), 32'h2, err);
	repeat (2) @(posedge clk);
	#1;
	count_pwm_high(n);
	check(n, 256, "disabled output follows invert set");
	apb_write(reg_addr(slot_pwm, PWM_CSR_OFFS), 0, err);
	repeat (2) @(posedge clk);
	#1;
	count_pwm_high(n);
	check(n, 0, "disabled output follows invert clear");
	report_test("pwm", base);
endtask

// ============================================================
//  Main sequence
// ============================================================

initial begin
	lfsr     = 32'hf333_8710;
	n_tests  = 0;
	n_checks = 0;
	n_errors = 0;
	reset    = 1'b1;
	psel     = 1'b0;
	penable  = 1'b0;
	pwrite   = 1'b0;
	paddr    = '0;
	pwdata   = '0;
	padin    = '0;
	repeat (3) @(posedge clk);
	#1;
	reset = 1'b0;
	gpio_regs_and_pins();
	decode_errors();
	uart_byte_stream();
	uart_interrupt();
	pwm_duty_cycle();
	$display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
	if (n_errors == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

/* files.f */
periph_pkg.sv
apb_splitter.sv
gpio.sv
uart_tx_mini.sv
pwm_tiny.sv
periph_top.sv
tb_periph_top.sv

/* Makefile */
# Verilator flow for the APB peripheral subsystem
VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 4

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# Passes only if the run prints the pass line
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)
